// ==== src/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath widths
`define WORD_WIDTH 32
`define PC_BITS    12 // Byte address, 4 KiB of program
`define REG_BITS   5

// Memory depths
`define IMEM_WORDS 1024
`define DMEM_BITS  10 // Word address, 4 KiB of data

////////////////////////////////////////
// Base opcodes, inst[6:0]
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011 // Register-immediate ALU ops
`define OPC_OP     7'b0110011 // Register-register ALU ops

`endif

// ==== src/core_pkg.sv ====
`include "core_defines.svh"

package core_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;      // Register and bus data
	typedef logic [`PC_BITS-1:0]    pc_t;        // Instruction byte address
	typedef logic [`REG_BITS-1:0]   reg_addr_t;
	typedef logic [`DMEM_BITS-1:0]  dmem_addr_t; // Data memory word index
	typedef logic [3:0]             byte_en_t;   // One bit per byte lane

	// ALU function
	// Also picks the compare for branches (SUB, SLT, SLTU)
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // LUI
	} alu_op_e;

	// Writeback source
	typedef enum logic [1:0] {
		WB_PC4,  // Link value of JAL and JALR
		WB_ALU,
		WB_LOAD
	} wb_sel_e;

	// Encoded as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_e;

	// Execute operand source
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

endpackage

// ==== src/decoder.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module decoder import core_pkg::*; (
	input  word_t     inst,
	output reg_addr_t rs1,           // Zero when unused
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output word_t     imm,
	output alu_op_e   alu_op,
	output logic      sel_pc_a,      // Operand A is the PC
	output logic      sel_imm_b,     // Operand B is the immediate
	output logic      is_branch,
	output logic      is_jal,
	output logic      is_jalr,
	output logic      is_load,
	output logic      is_store,
	output mem_size_e mem_size,
	output logic      load_unsigned, // Branch condition invert on branches
	output wb_sel_e   wb_sel,
	output logic      wr_en
);

	logic [2:0] funct3;
	logic       alt;      // inst[30], SUB and SRA
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	alu_op_e    arith_op;

	assign funct3 = inst[14:12];
	assign alt    = inst[30];

	// Immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// Only meaningful for loads and stores
	assign mem_size = funct3[1] ? MEM_WORD : (funct3[0] ? MEM_HALF : MEM_BYTE);

	// OP and OP-IMM function
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (alt && inst[6:0] == `OPC_OP) ? ALU_SUB : ALU_ADD; // No SUBI
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		// Bubble by default
		rs1           = '0;
		rs2           = '0;
		rd            = '0;
		imm           = '0;
		alu_op        = ALU_ADD;
		sel_pc_a      = 1'b0;
		sel_imm_b     = 1'b0;
		is_branch     = 1'b0;
		is_jal        = 1'b0;
		is_jalr       = 1'b0;
		is_load       = 1'b0;
		is_store      = 1'b0;
		load_unsigned = funct3[2]; // LBU, LHU
		wb_sel        = WB_ALU;
		wr_en         = 1'b0;
		case (inst[6:0])
			`OPC_LUI, `OPC_AUIPC: begin
				rd        = inst[11:7];
				imm       = imm_u;
				alu_op    = (inst[5]) ? ALU_PASS_B : ALU_ADD; // AUIPC adds the PC
				sel_pc_a  = !inst[5];
				sel_imm_b = 1'b1;
				wr_en     = 1'b1;
			end
			`OPC_JAL: begin
				rd     = inst[11:7];
				imm    = imm_j;
				is_jal = 1'b1;
				wb_sel = WB_PC4;
				wr_en  = 1'b1;
			end
			`OPC_JALR: begin
				rd        = inst[11:7];
				rs1       = inst[19:15];
				imm       = imm_i;
				sel_imm_b = 1'b1;  // ALU forms rs1 + imm
				is_jalr   = 1'b1;
				wb_sel    = WB_PC4;
				wr_en     = 1'b1;
			end
			`OPC_BRANCH: begin
				rs1           = inst[19:15];
				rs2           = inst[24:20];
				imm           = imm_b;
				is_branch     = 1'b1;
				alu_op        = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
				load_unsigned = funct3[0] ^ ~funct3[2]; // BEQ, BGE, BGEU take on zero
			end
			`OPC_LOAD: begin
				rd        = inst[11:7];
				rs1       = inst[19:15];
				imm       = imm_i;
				sel_imm_b = 1'b1;
				is_load   = 1'b1;
				wb_sel    = WB_LOAD;
				wr_en     = 1'b1;
			end
			`OPC_STORE: begin
				rs1       = inst[19:15];
				rs2       = inst[24:20]; // Store data
				imm       = imm_s;
				sel_imm_b = 1'b1;
				is_store  = 1'b1;
			end
			`OPC_OPIMM, `OPC_OP: begin
				rd        = inst[11:7];
				rs1       = inst[19:15];
				rs2       = inst[5] ? inst[24:20] : '0;
				imm       = imm_i;
				alu_op    = arith_op;
				sel_imm_b = !inst[5];
				wr_en     = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile import core_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	input  logic      wr_en,
	input  reg_addr_t wr_rd,
	input  word_t     wr_data,
	output word_t     rd1,
	output word_t     rd2
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_rd != '0) begin
			regs[wr_rd] <= wr_data;
		end
	end

	// Write-first, so decode sees the instruction retiring this cycle
	assign rd1 = (rs1 == '0) ? '0 : (wr_en && wr_rd == rs1) ? wr_data : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (wr_en && wr_rd == rs2) ? wr_data : regs[rs2];

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
	input  reg_addr_t id_rs1,
	input  reg_addr_t id_rs2,
	input  reg_addr_t ex_rs1,
	input  reg_addr_t ex_rs2,
	input  reg_addr_t ex_rd,
	input  logic      ex_is_load,
	input  logic      ex_wr_en,
	input  reg_addr_t mem_rd,
	input  logic      mem_wr_en,
	input  reg_addr_t wb_rd,
	input  logic      wb_wr_en,
	input  logic      redirect,
	output logic      stall,
	output logic      flush,
	output fwd_sel_e  fwd_a,
	output fwd_sel_e  fwd_b
);

	logic load_use;

	// Youngest writer first and x0 never forwards
	function automatic fwd_sel_e pick_source(input reg_addr_t rs, input logic m_wr_en,
			input reg_addr_t m_rd, input logic w_wr_en, input reg_addr_t w_rd);
		if (rs == '0)
			return FWD_REG;
		if (m_wr_en && m_rd == rs)
			return FWD_MEM;
		if (w_wr_en && w_rd == rs)
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign fwd_a = pick_source(ex_rs1, mem_wr_en, mem_rd, wb_wr_en, wb_rd);
	assign fwd_b = pick_source(ex_rs2, mem_wr_en, mem_rd, wb_wr_en, wb_rd);

	// Load data only exists in MEM so one bubble lets WB forward it
	assign load_use = ex_is_load && ex_wr_en && (ex_rd != '0)
		&& (ex_rd == id_rs1 || ex_rd == id_rs2);

	assign stall = load_use && !redirect; // Redirect wins
	assign flush = redirect;              // Kills IF/ID and ID/EX

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_stage import core_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                flush,
	input  logic                redirect,
	input  pc_t                 redirect_pc,
	input  logic                prog_write,
	input  logic [`PC_BITS-3:0] prog_addr,   // Word address
	input  word_t               prog_data,
	output word_t               id_inst,
	output pc_t                 id_pc,
	output logic                id_valid
);

	pc_t   pc;
	word_t imem [`IMEM_WORDS];
	word_t if_inst;

	assign if_inst = imem[pc[`PC_BITS-1:2]]; // Async read

	// Loader port, only driven while the core is in reset
	always_ff @(posedge clk) begin
		if (prog_write)
			imem[prog_addr] <= prog_data;
	end

	// Predict not-taken
	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (redirect)
			pc <= redirect_pc; // Overrides stall
		else if (!stall)
			pc <= pc + pc_t'(4);
	end

	////////////////////////////////////////
	// IF/ID register
	always_ff @(posedge clk) begin
		if (reset || flush)
			id_valid <= 1'b0;
		else if (!stall)
			id_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_inst <= if_inst;
			id_pc   <= pc;
		end
	end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       stall,
	input  logic       flush,
	// Decoder fields
	input  reg_addr_t  id_rs1,
	input  reg_addr_t  id_rs2,
	input  reg_addr_t  id_rd,
	input  word_t      id_imm,
	input  alu_op_e    id_alu_op,
	input  logic       id_sel_pc_a,
	input  logic       id_sel_imm_b,
	input  logic       id_is_branch,
	input  logic       id_is_jal,
	input  logic       id_is_jalr,
	input  logic       id_is_load,
	input  logic       id_is_store,
	input  mem_size_e  id_mem_size,
	input  logic       id_load_unsigned,
	input  wb_sel_e    id_wb_sel,
	input  logic       id_wr_en,
	input  pc_t        id_pc,
	input  word_t      rd1,
	input  word_t      rd2,
	// Forwarding
	input  fwd_sel_e   fwd_a,
	input  fwd_sel_e   fwd_b,
	input  word_t      mem_result,
	input  word_t      wb_result,
	output reg_addr_t  ex_rs1,
	output reg_addr_t  ex_rs2,
	output reg_addr_t  ex_rd,
	output logic       ex_is_load,
	output logic       ex_wr_en,
	output logic       redirect,
	output pc_t        redirect_pc,
	// Data memory, EX-stage timing
	output dmem_addr_t dmem_addr,
	output byte_en_t   dmem_be,
	output word_t      dmem_wdata,
	// EX/MEM register
	output reg_addr_t  mem_rd,
	output logic       mem_wr_en,
	output wb_sel_e    mem_wb_sel,
	output word_t      mem_alu_out,
	output pc_t        mem_pc4,
	output mem_size_e  mem_size,
	output logic       mem_load_unsigned,
	output logic [1:0] mem_byte_off
);

	word_t     ex_imm;
	alu_op_e   ex_alu_op;
	logic      ex_sel_pc_a;
	logic      ex_sel_imm_b;
	logic      ex_is_branch;
	logic      ex_is_jal;
	logic      ex_is_jalr;
	logic      ex_is_store;
	mem_size_e ex_mem_size;
	logic      ex_load_unsigned;
	wb_sel_e   ex_wb_sel;
	pc_t       ex_pc;
	word_t     ex_rd1;
	word_t     ex_rd2;
	word_t     src_a;      // Forwarded rs1
	word_t     src_b;      // Forwarded rs2, also store data
	word_t     op_a;
	word_t     op_b;
	word_t     alu_out;
	logic      taken;

	////////////////////////////////////////
	// ID/EX register, stall and flush insert a bubble
	always_ff @(posedge clk) begin
		if (reset || flush || stall)
			{ex_is_branch, ex_is_jal, ex_is_jalr, ex_is_load, ex_is_store, ex_wr_en} <= '0;
		else
			{ex_is_branch, ex_is_jal, ex_is_jalr, ex_is_load, ex_is_store, ex_wr_en} <=
				{id_is_branch, id_is_jal, id_is_jalr, id_is_load, id_is_store, id_wr_en};
	end

	always_ff @(posedge clk) begin
		ex_rs1           <= id_rs1;
		ex_rs2           <= id_rs2;
		ex_rd            <= id_rd;
		ex_imm           <= id_imm;
		ex_alu_op        <= id_alu_op;
		ex_sel_pc_a      <= id_sel_pc_a;
		ex_sel_imm_b     <= id_sel_imm_b;
		ex_mem_size      <= id_mem_size;
		ex_load_unsigned <= id_load_unsigned;
		ex_wb_sel        <= id_wb_sel;
		ex_pc            <= id_pc;
		ex_rd1           <= rd1;
		ex_rd2           <= rd2;
	end

	// Operand muxes
	assign src_a = (fwd_a == FWD_MEM) ? mem_result : (fwd_a == FWD_WB) ? wb_result : ex_rd1;
	assign src_b = (fwd_b == FWD_MEM) ? mem_result : (fwd_b == FWD_WB) ? wb_result : ex_rd2;
	assign op_a  = ex_sel_pc_a ? word_t'(ex_pc) : src_a;  // AUIPC
	assign op_b  = ex_sel_imm_b ? ex_imm : src_b;

	// ALU
	always_comb begin
		case (ex_alu_op)
			ALU_ADD:  alu_out = op_a + op_b;
			ALU_SUB:  alu_out = op_a - op_b;
			ALU_SLL:  alu_out = op_a << op_b[4:0];
			ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_out = word_t'(op_a < op_b);
			ALU_XOR:  alu_out = op_a ^ op_b;
			ALU_SRL:  alu_out = op_a >> op_b[4:0];
			ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
			ALU_OR:   alu_out = op_a | op_b;
			ALU_AND:  alu_out = op_a & op_b;
			default:  alu_out = op_b; // PASS_B
		endcase
	end

	// Branch resolves here, invert bit rides on load_unsigned
	assign taken       = (alu_out != '0) ^ ex_load_unsigned;
	assign redirect    = ex_is_jal || ex_is_jalr || (ex_is_branch && taken);
	assign redirect_pc = ex_is_jalr ? {alu_out[`PC_BITS-1:1], 1'b0}
		: ex_pc + ex_imm[`PC_BITS-1:0];

	////////////////////////////////////////
	// Store alignment, data replicated across lanes
	assign dmem_addr = alu_out[`DMEM_BITS+1:2];

	always_comb begin
		case (ex_mem_size)
			MEM_BYTE: begin
				dmem_wdata = {4{src_b[7:0]}};
				dmem_be    = 4'b0001 << alu_out[1:0];
			end
			MEM_HALF: begin
				dmem_wdata = {2{src_b[15:0]}};
				dmem_be    = alu_out[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dmem_wdata = src_b;
				dmem_be    = 4'b1111;
			end
		endcase
		if (!ex_is_store)
			dmem_be = '0; // No write
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset)
			mem_wr_en <= 1'b0;
		else
			mem_wr_en <= ex_wr_en;
	end

	always_ff @(posedge clk) begin
		mem_rd            <= ex_rd;
		mem_wb_sel        <= ex_wb_sel;
		mem_alu_out       <= alu_out;
		mem_pc4           <= ex_pc + pc_t'(4); // Link value
		mem_size          <= ex_mem_size;
		mem_load_unsigned <= ex_load_unsigned;
		mem_byte_off      <= alu_out[1:0];
	end

endmodule

// ==== src/data_memory.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module data_memory import core_pkg::*; (
	input  logic       clk,
	// Core port, address from EX
	input  dmem_addr_t dmem_addr,
	input  byte_en_t   dmem_be,
	input  word_t      dmem_wdata,
	// Load format, from MEM
	input  mem_size_e  mem_size,
	input  logic       load_unsigned,
	input  logic [1:0] byte_off,
	// Protocol controller port
	input  byte_en_t   con_write,
	input  dmem_addr_t con_addr,
	input  word_t      con_in,
	output word_t      load_data,
	output word_t      con_out
);

	word_t      mem [2**`DMEM_BITS];
	word_t      core_q;    // Raw word for the MEM stage
	logic [7:0] sel_byte;
	logic [15:0] sel_half;

	// True dual-port, core write lands last so it wins a collision
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (con_write[i])
				mem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
		end
		for (int i = 0; i < 4; i++) begin
			if (dmem_be[i])
				mem[dmem_addr][8*i +: 8] <= dmem_wdata[8*i +: 8];
		end
		core_q  <= mem[dmem_addr];
		con_out <= mem[con_addr];  // Valid the cycle after con_addr
	end

	////////////////////////////////////////
	// Load extraction
	assign sel_byte = core_q[{byte_off, 3'b000} +: 8];
	assign sel_half = byte_off[1] ? core_q[31:16] : core_q[15:0];

	always_comb begin
		case (mem_size)
			MEM_BYTE: load_data = {{24{~load_unsigned & sel_byte[7]}}, sel_byte};
			MEM_HALF: load_data = {{16{~load_unsigned & sel_half[15]}}, sel_half};
			default:  load_data = core_q;
		endcase
	end

endmodule

// ==== src/core.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module core import core_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	// Program load, word addressed
	input  logic                prog_write,
	input  logic [`PC_BITS-3:0] prog_addr,
	input  word_t               prog_data,
	// Protocol controller port
	input  byte_en_t            con_write,
	input  dmem_addr_t          con_addr,
	input  word_t               con_in,
	output word_t               con_out,
	// One pulse per register write
	output logic                retire_valid,
	output reg_addr_t           retire_rd,
	output word_t               retire_data
);

	// ID stage
	word_t      id_inst;
	pc_t        id_pc;
	logic       id_valid;
	word_t      dec_inst;     // Decoder input, zero on a bubble
	reg_addr_t  id_rs1;
	reg_addr_t  id_rs2;
	reg_addr_t  id_rd;
	word_t      id_imm;
	alu_op_e    id_alu_op;
	logic       id_sel_pc_a;
	logic       id_sel_imm_b;
	logic       id_is_branch;
	logic       id_is_jal;
	logic       id_is_jalr;
	logic       id_is_load;
	logic       id_is_store;
	mem_size_e  id_mem_size;
	logic       id_load_unsigned;
	wb_sel_e    id_wb_sel;
	logic       id_wr_en;
	word_t      id_rd1;
	word_t      id_rd2;

	// Hazard control
	logic       stall;
	logic       flush;
	fwd_sel_e   fwd_a;
	fwd_sel_e   fwd_b;

	// EX stage
	reg_addr_t  ex_rs1;
	reg_addr_t  ex_rs2;
	reg_addr_t  ex_rd;
	logic       ex_is_load;
	logic       ex_wr_en;
	logic       redirect;
	pc_t        redirect_pc;
	dmem_addr_t dmem_addr;
	byte_en_t   dmem_be;
	word_t      dmem_wdata;

	// MEM stage
	reg_addr_t  mem_rd;
	logic       mem_wr_en;
	wb_sel_e    mem_wb_sel;
	word_t      mem_alu_out;
	pc_t        mem_pc4;
	mem_size_e  mem_size;
	logic       mem_load_unsigned;
	logic [1:0] mem_byte_off;
	word_t      mem_load_data;
	word_t      mem_result;   // Forwarded to EX

	// WB stage
	reg_addr_t  wb_rd;
	logic       wb_wr_en;
	wb_sel_e    wb_sel;
	word_t      wb_alu_out;
	pc_t        wb_pc4;
	word_t      wb_load_data;
	word_t      wb_result;

	////////////////////////////////////////
	// IF and ID
	fetch_stage u_fetch (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.flush       (flush),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.prog_write  (prog_write),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.id_inst     (id_inst),
		.id_pc       (id_pc),
		.id_valid    (id_valid)
	);

	assign dec_inst = id_valid ? id_inst : '0; // Opcode 0 decodes as a bubble

	decoder u_decoder (
		.inst          (dec_inst),
		.rs1           (id_rs1),
		.rs2           (id_rs2),
		.rd            (id_rd),
		.imm           (id_imm),
		.alu_op        (id_alu_op),
		.sel_pc_a      (id_sel_pc_a),
		.sel_imm_b     (id_sel_imm_b),
		.is_branch     (id_is_branch),
		.is_jal        (id_is_jal),
		.is_jalr       (id_is_jalr),
		.is_load       (id_is_load),
		.is_store      (id_is_store),
		.mem_size      (id_mem_size),
		.load_unsigned (id_load_unsigned),
		.wb_sel        (id_wb_sel),
		.wr_en         (id_wr_en)
	);

	regfile u_regfile (
		.clk     (clk),
		.reset   (reset),
		.rs1     (id_rs1),
		.rs2     (id_rs2),
		.wr_en   (wb_wr_en),
		.wr_rd   (wb_rd),
		.wr_data (wb_result),
		.rd1     (id_rd1),
		.rd2     (id_rd2)
	);

	hazard_unit u_hazard (.*); // Names match the stage wires

	////////////////////////////////////////
	// EX and MEM
	execute_stage u_execute (
		.*,
		.rd1 (id_rd1),
		.rd2 (id_rd2)
	);

	// Loads never need this path, the load-use stall covers them
	assign mem_result = (mem_wb_sel == WB_PC4) ? word_t'(mem_pc4) : mem_alu_out;

	data_memory u_dmem (
		.clk           (clk),
		.dmem_addr     (dmem_addr),   // EX-stage address, read lands in MEM
		.dmem_be       (dmem_be),
		.dmem_wdata    (dmem_wdata),
		.mem_size      (mem_size),
		.load_unsigned (mem_load_unsigned),
		.byte_off      (mem_byte_off),
		.con_write     (con_write),
		.con_addr      (con_addr),
		.con_in        (con_in),
		.load_data     (mem_load_data),
		.con_out       (con_out)
	);

	////////////////////////////////////////
	// MEM/WB register and writeback
	always_ff @(posedge clk) begin
		if (reset)
			wb_wr_en <= 1'b0;
		else
			wb_wr_en <= mem_wr_en;
	end

	always_ff @(posedge clk) begin
		wb_rd        <= mem_rd;
		wb_sel       <= mem_wb_sel;
		wb_alu_out   <= mem_alu_out;
		wb_pc4       <= mem_pc4;
		wb_load_data <= mem_load_data;
	end

	always_comb begin
		case (wb_sel)
			WB_PC4:  wb_result = word_t'(wb_pc4);
			WB_LOAD: wb_result = wb_load_data;
			default: wb_result = wb_alu_out;
		endcase
	end

	assign retire_valid = wb_wr_en && (wb_rd != '0); // x0 writes are dropped
	assign retire_rd    = wb_rd;
	assign retire_data  = wb_result;

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	input  logic load_done, // Program image is in place
	output logic clk,
	output logic reset
);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	// Reset covers the program load, then two more cycles
	initial begin
		reset = 1'b1;
		wait (load_done);
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== verification/tb_core.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core;

	localparam logic [6:0] opc_lui   = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jalr  = 7'b1100111;
	localparam logic [6:0] opc_load  = 7'b0000011;
	localparam logic [6:0] opc_imm   = 7'b0010011;
	localparam int         traffic_ops = 24; // Controller-port write/read pairs

	logic                  clk;
	logic                  reset;
	logic                  load_done;
	logic                  prog_write;
	logic [`PC_BITS-3:0]   prog_addr;
	logic [31:0]           prog_data;
	logic [3:0]            con_write;
	logic [`DMEM_BITS-1:0] con_addr;
	logic [31:0]           con_in;
	logic [31:0]           con_out;
	logic                  retire_valid;
	logic [4:0]            retire_rd;
	logic [31:0]           retire_data;

	// Program table, one row per instruction word
	logic [31:0] row_inst [$];
	bit          row_ret  [$];
	logic [4:0]  row_rd   [$];
	logic [31:0] row_val  [$];
	logic [4:0]  exp_rd   [$]; // Retiring rows only, in order
	logic [31:0] exp_val  [$];
	int          ret_idx = 0;
	bit          table_ready = 1'b0;
	logic [31:0] lfsr = 32'h1c60;

	// Data words the program leaves behind
	logic [`DMEM_BITS-1:0] final_addr [3] = '{10'h040, 10'h041, 10'h042};
	logic [31:0]           final_word [3] = '{32'h1234_5678, 32'h5500_fffb, 32'h0555_a987};

	tb_clock_gen clock_gen (.load_done(load_done), .clk(clk), .reset(reset));

	core DUT (.*);

	////////////////////////////////////////
	// Instruction formats
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Galois form, taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]}; // One step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	////////////////////////////////////////
	// Failure reporting
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, expected));
	endtask

	task automatic add_row(input logic [31:0] inst, input bit ret, input logic [4:0] rd,
			input logic [31:0] val);
		row_inst.push_back(inst);
		row_ret.push_back(ret);
		row_rd.push_back(rd);
		row_val.push_back(val);
	endtask

	////////////////////////////////////////
	// Program, PC is four times the row index
	task automatic build_program();
		logic [31:0] poison;
		poison = i_type(12'h7ff, 5'd0, 3'b000, 5'd5, opc_imm); // Must never retire
		add_row(u_type(20'h12345, 5'd1, opc_lui), 1, 5'd1, 32'h1234_5000);
		add_row(i_type(12'h678, 5'd1, 3'b000, 5'd1, opc_imm), 1, 5'd1, 32'h1234_5678);
		add_row(u_type(20'h00001, 5'd2, opc_auipc), 1, 5'd2, 32'h0000_1008); // PC 8
		add_row(i_type(12'hffb, 5'd0, 3'b000, 5'd3, opc_imm), 1, 5'd3, 32'hffff_fffb);
		add_row(r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd4), 1, 5'd4, 32'h1234_5673); // add
		add_row(r_type(7'h20, 5'd1, 5'd4, 3'b000, 5'd5), 1, 5'd5, 32'hffff_fffb); // sub
		add_row(r_type(7'h00, 5'd0, 5'd3, 3'b010, 5'd6), 1, 5'd6, 32'h0000_0001); // slt
		add_row(r_type(7'h00, 5'd1, 5'd3, 3'b011, 5'd7), 1, 5'd7, 32'h0000_0000); // sltu
		add_row(r_type(7'h00, 5'd3, 5'd1, 3'b100, 5'd8), 1, 5'd8, 32'hedcb_a983); // xor
		add_row(r_type(7'h00, 5'd2, 5'd6, 3'b110, 5'd9), 1, 5'd9, 32'h0000_1009); // or
		add_row(i_type(12'h0f0, 5'd1, 3'b111, 5'd10, opc_imm), 1, 5'd10, 32'h0000_0070);
		add_row(i_type(12'h004, 5'd1, 3'b001, 5'd11, opc_imm), 1, 5'd11, 32'h2345_6780);
		add_row(i_type(12'h01c, 5'd3, 3'b101, 5'd12, opc_imm), 1, 5'd12, 32'h0000_000f);
		add_row(i_type(12'h401, 5'd3, 3'b101, 5'd13, opc_imm), 1, 5'd13, 32'hffff_fffd);
		add_row(r_type(7'h00, 5'd6, 5'd1, 3'b001, 5'd14), 1, 5'd14, 32'h2468_acf0); // sll
		add_row(r_type(7'h00, 5'd6, 5'd8, 3'b101, 5'd15), 1, 5'd15, 32'h76e5_d4c1); // srl
		add_row(r_type(7'h20, 5'd6, 5'd8, 3'b101, 5'd16), 1, 5'd16, 32'hf6e5_d4c1); // sra
		add_row(i_type(12'hffc, 5'd3, 3'b010, 5'd17, opc_imm), 1, 5'd17, 32'h0000_0001);
		add_row(i_type(12'h001, 5'd6, 3'b011, 5'd18, opc_imm), 1, 5'd18, 32'h0000_0000);
		add_row(i_type(12'hfff, 5'd1, 3'b100, 5'd19, opc_imm), 1, 5'd19, 32'hedcb_a987);
		add_row(i_type(12'h555, 5'd0, 3'b110, 5'd20, opc_imm), 1, 5'd20, 32'h0000_0555);
		add_row(i_type(12'h100, 5'd0, 3'b000, 5'd21, opc_imm), 1, 5'd21, 32'h0000_0100);
		// Stores around byte address 0x100
		add_row(s_type(12'h000, 5'd1, 5'd21, 3'b010), 0, 5'd0, 32'h0); // sw
		add_row(s_type(12'h004, 5'd0, 5'd21, 3'b010), 0, 5'd0, 32'h0); // sw x0
		add_row(s_type(12'h004, 5'd3, 5'd21, 3'b001), 0, 5'd0, 32'h0); // sh
		add_row(s_type(12'h007, 5'd20, 5'd21, 3'b000), 0, 5'd0, 32'h0); // sb
		add_row(s_type(12'h008, 5'd19, 5'd21, 3'b010), 0, 5'd0, 32'h0);
		add_row(s_type(12'h00a, 5'd20, 5'd21, 3'b001), 0, 5'd0, 32'h0); // Upper half
		add_row(i_type(12'h000, 5'd21, 3'b010, 5'd22, opc_load), 1, 5'd22, 32'h1234_5678);
		add_row(i_type(12'h004, 5'd21, 3'b000, 5'd23, opc_load), 1, 5'd23, 32'hffff_fffb);
		add_row(i_type(12'h004, 5'd21, 3'b100, 5'd24, opc_load), 1, 5'd24, 32'h0000_00fb);
		add_row(i_type(12'h008, 5'd21, 3'b001, 5'd25, opc_load), 1, 5'd25, 32'hffff_a987);
		add_row(i_type(12'h008, 5'd21, 3'b101, 5'd26, opc_load), 1, 5'd26, 32'h0000_a987);
		add_row(i_type(12'h007, 5'd21, 3'b000, 5'd27, opc_load), 1, 5'd27, 32'h0000_0055);
		// Load-use pairs, rs1 then rs2
		add_row(i_type(12'h008, 5'd21, 3'b010, 5'd28, opc_load), 1, 5'd28, 32'h0555_a987);
		add_row(r_type(7'h00, 5'd22, 5'd28, 3'b000, 5'd29), 1, 5'd29, 32'h1789_ffff);
		add_row(i_type(12'h005, 5'd21, 3'b100, 5'd30, opc_load), 1, 5'd30, 32'h0000_00ff);
		add_row(r_type(7'h20, 5'd30, 5'd0, 3'b000, 5'd31), 1, 5'd31, 32'hffff_ff01);
		////////////////////////////////////////
		// Branches, x3 is -5 and x6 is 1
		add_row(b_type(13'd12, 5'd6, 5'd6, 3'b000), 0, 5'd0, 32'h0); // beq taken
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(b_type(13'd12, 5'd6, 5'd6, 3'b001), 0, 5'd0, 32'h0); // bne falls through
		add_row(i_type(12'h011, 5'd0, 3'b000, 5'd5, opc_imm), 1, 5'd5, 32'h0000_0011);
		add_row(b_type(13'd12, 5'd6, 5'd3, 3'b001), 0, 5'd0, 32'h0); // bne taken
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(b_type(13'd8, 5'd6, 5'd3, 3'b100), 0, 5'd0, 32'h0);  // blt taken
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(b_type(13'd8, 5'd3, 5'd6, 3'b100), 0, 5'd0, 32'h0);
		add_row(i_type(12'h022, 5'd0, 3'b000, 5'd5, opc_imm), 1, 5'd5, 32'h0000_0022);
		add_row(b_type(13'd8, 5'd3, 5'd6, 3'b101), 0, 5'd0, 32'h0);  // bge taken
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(b_type(13'd8, 5'd6, 5'd3, 3'b101), 0, 5'd0, 32'h0);
		add_row(i_type(12'h033, 5'd0, 3'b000, 5'd5, opc_imm), 1, 5'd5, 32'h0000_0033);
		add_row(b_type(13'd8, 5'd3, 5'd6, 3'b110), 0, 5'd0, 32'h0);  // bltu taken
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(b_type(13'd8, 5'd6, 5'd3, 3'b110), 0, 5'd0, 32'h0);
		add_row(i_type(12'h044, 5'd0, 3'b000, 5'd5, opc_imm), 1, 5'd5, 32'h0000_0044);
		add_row(b_type(13'd8, 5'd6, 5'd3, 3'b111), 0, 5'd0, 32'h0);  // bgeu taken
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(b_type(13'd8, 5'd3, 5'd6, 3'b111), 0, 5'd0, 32'h0);
		add_row(i_type(12'h055, 5'd0, 3'b000, 5'd5, opc_imm), 1, 5'd5, 32'h0000_0055);
		add_row(b_type(13'd8, 5'd0, 5'd6, 3'b000), 0, 5'd0, 32'h0);  // beq not taken
		add_row(i_type(12'h066, 5'd0, 3'b000, 5'd5, opc_imm), 1, 5'd5, 32'h0000_0066);
		add_row(i_type(12'h007, 5'd0, 3'b000, 5'd7, opc_imm), 1, 5'd7, 32'h0000_0007);
		add_row(b_type(13'd8, 5'd0, 5'd7, 3'b001), 0, 5'd0, 32'h0);  // Forwarded compare
		add_row(poison, 0, 5'd0, 32'h0);
		// Jumps, link is PC plus four
		add_row(j_type(21'd12, 5'd1), 1, 5'd1, 32'h0000_0110); // PC 0x10c
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(u_type(20'h00000, 5'd2, opc_auipc), 1, 5'd2, 32'h0000_0118);
		add_row(i_type(12'h010, 5'd2, 3'b000, 5'd3, opc_jalr), 1, 5'd3, 32'h0000_0120);
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(poison, 0, 5'd0, 32'h0);
		add_row(r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd4), 1, 5'd4, 32'h0000_0230);
		add_row(j_type(21'd0, 5'd0), 0, 5'd0, 32'h0); // Park here
		add_row(i_type(12'h000, 5'd0, 3'b000, 5'd0, opc_imm), 0, 5'd0, 32'h0);
		add_row(i_type(12'h000, 5'd0, 3'b000, 5'd0, opc_imm), 0, 5'd0, 32'h0);
	endtask

	////////////////////////////////////////
	// Controller-port traffic above the program's data
	task automatic controller_traffic(input int count);
		logic [31:0] addr_bits;
		logic [31:0] data;
		for (int n = 0; n < count; n++) begin
			random_bits(9, addr_bits);
			random_bits(32, data);
			@(negedge clk);
			con_write = 4'hf;
			con_addr  = {1'b1, addr_bits[8:0]}; // Word 0x200 and up
			con_in    = data;
			@(negedge clk);
			con_write = 4'h0;
			@(negedge clk); // Read data registered on the last edge
			check_value($sformatf("con_out at %h", con_addr), con_out, data);
		end
	endtask

	task automatic read_word(input logic [`DMEM_BITS-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		con_write = 4'h0;
		con_addr  = addr;
		@(negedge clk);
		data = con_out;
	endtask

	// Retire monitor
	always @(negedge clk) begin
		if (!reset && retire_valid === 1'b1) begin
			if (ret_idx >= exp_rd.size()) begin
				fail_run("a register write retired after the last expected one");
			end else begin
				check_value($sformatf("retire_rd, retire %0d", ret_idx),
					{27'b0, retire_rd}, {27'b0, exp_rd[ret_idx]});
				check_value($sformatf("retire_data, retire %0d", ret_idx),
					retire_data, exp_val[ret_idx]);
				ret_idx++;
			end
		end
	end

	// Watchdog, twenty cycles per row and traffic pair
	initial begin
		wait (table_ready);
		repeat ((row_inst.size() + traffic_ops) * 20) @(posedge clk);
		fail_run("timeout: the program did not retire all expected writes in time");
	end

	initial begin
		logic [31:0] word;
		prog_write = 1'b0;
		prog_addr  = '0;
		prog_data  = '0;
		con_write  = 4'h0;
		con_addr   = '0;
		con_in     = '0;
		load_done  = 1'b0;
		build_program();
		for (int i = 0; i < row_inst.size(); i++) begin
			if (row_ret[i]) begin
				exp_rd.push_back(row_rd[i]);
				exp_val.push_back(row_val[i]);
			end
		end
		table_ready = 1'b1;
		// Load while the core is held in reset
		for (int i = 0; i < row_inst.size(); i++) begin
			@(negedge clk);
			prog_write = 1'b1;
			prog_addr  = (`PC_BITS-2)'(i);
			prog_data  = row_inst[i];
		end
		@(negedge clk);
		prog_write = 1'b0;
		load_done  = 1'b1;
		wait (reset == 1'b0);
		fork
			controller_traffic(traffic_ops);
			wait (ret_idx == exp_rd.size());
		join
		repeat (10) @(negedge clk); // Room for a stray retire
		for (int i = 0; i < 3; i++) begin
			read_word(final_addr[i], word);
			check_value($sformatf("con_out at %h", final_addr[i]), word, final_word[i]);
		end
		$display("sim passed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+src
src/core_pkg.sv
src/decoder.sv
src/regfile.sv
src/hazard_unit.sv
src/fetch_stage.sv
src/execute_stage.sv
src/data_memory.sv
src/core.sv
verification/tb_clock_gen.sv
verification/tb_core.sv

// ==== Makefile ====
TOP = tb_core

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f -o vsim

run: build
	./obj_dir/vsim | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
